/* compile.f */
+incdir+hw
hw/eth_rx_tile_pkg.sv
hw/noc_msg_steer.sv
hw/flit_fifo.sv
hw/eth_rx_noc_in.sv
hw/mac_frame_merge.sv
hw/eth_rx_tile.sv
testbench/tb_eth_rx_tile.sv

/* hw/eth_rx_noc_in.sv */
`include "eth_rx_tile_cfg.svh"

module eth_rx_noc_in import eth_rx_tile_pkg::*; (
     input  logic       clk
    ,input  logic       rst

    ,input  logic       deq_val
    ,input  lane_flit_t deq_flit
    ,output logic       deq_rdy

    ,output logic       beat_val
    ,output mac_beat_t  beat
    ,input  logic       beat_rdy
);

    typedef enum logic {
        HDR  = 1'b0,
        DATA = 1'b1
    } state_e;

    state_e                       state_reg;
    state_e                       state_next;

    eth_rx_hdr_flit               hdr_cast;
    logic [`MTU_SIZE_W-1:0]       frame_size_reg;
    logic                         store_hdr;
    logic [`NOC_DATA_BYTES_W-1:0] tail_bytes;
    logic [`MAC_PADBYTES_W-1:0]   pad_bytes;

    assign hdr_cast = deq_flit.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= HDR;
        end
        else begin
            state_reg <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_hdr) begin
            frame_size_reg <= hdr_cast.frame_size;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // beat fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign tail_bytes = frame_size_reg[`NOC_DATA_BYTES_W-1:0];  // bytes used in the last flit.
    assign pad_bytes  = (tail_bytes == '0)
                        ? '0
                        : `MAC_PADBYTES_W'(`NOC_DATA_BYTES - tail_bytes);

    assign beat.data       = deq_flit.data;
    assign beat.last       = deq_flit.msg_end;
    assign beat.padbytes   = pad_bytes;
    assign beat.frame_size = frame_size_reg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // header and data FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        deq_rdy    = 1'b0;
        beat_val   = 1'b0;
        store_hdr  = 1'b0;
        state_next = state_reg;
        case (state_reg)
            HDR: begin
                deq_rdy = 1'b1;  // the header is consumed without waiting on the MAC.
                if (deq_val) begin
                    store_hdr  = 1'b1;
                    state_next = DATA;
                end
            end
            DATA: begin
                beat_val = deq_val;
                deq_rdy  = beat_rdy;
                if (deq_val && beat_rdy && deq_flit.msg_end) begin
                    state_next = HDR;
                end
            end
            default: begin
                state_next = HDR;
            end
        endcase
    end

    a_no_beat_in_hdr: assert property (@(posedge clk) disable iff (rst)
        (state_reg == HDR) |-> !beat_val);

    // the steer must have tagged the flit that opens every message.
    a_hdr_tagged: assert property (@(posedge clk) disable iff (rst)
        (state_reg == HDR && deq_val) |-> deq_flit.is_hdr);

endmodule

/* hw/eth_rx_tile.sv */
`include "eth_rx_tile_cfg.svh"

module eth_rx_tile import eth_rx_tile_pkg::*; (
     input  logic                       clk
    ,input  logic                       rst

    ,input  logic                       noc_in_val
    ,input  logic [`NOC_DATA_WIDTH-1:0] noc_in_data
    ,output logic                       noc_in_rdy

    ,output logic                       mac_val
    ,output mac_beat_t                  mac_beat
    ,input  logic                       mac_rdy
);

    logic [`RX_LANES-1:0] lane_full;
    logic [`RX_LANES-1:0] lane_push;
    lane_flit_t           lane_flit;

    logic [`RX_LANES-1:0] deq_val;
    logic [`RX_LANES-1:0] deq_rdy;
    lane_flit_t           deq_flit [`RX_LANES];

    logic [`RX_LANES-1:0] beat_val;
    logic [`RX_LANES-1:0] beat_rdy;
    mac_beat_t            beat [`RX_LANES];

    noc_msg_steer u_noc_msg_steer (
         .clk         (clk)
        ,.rst         (rst)
        ,.noc_in_val  (noc_in_val)
        ,.noc_in_data (noc_in_data)
        ,.noc_in_rdy  (noc_in_rdy)
        ,.lane_full   (lane_full)
        ,.lane_push   (lane_push)
        ,.lane_flit   (lane_flit)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // per-lane FIFO and deframer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar i = 0; i < `RX_LANES; i++) begin : g_lane
        flit_fifo #(
            .DEPTH (`LANE_FIFO_DEPTH)
        ) u_flit_fifo (
             .clk       (clk)
            ,.rst       (rst)
            ,.push      (lane_push[i])
            ,.push_flit (lane_flit)  // the bus is shared and only the selected lane pushes.
            ,.full      (lane_full[i])
            ,.deq_val   (deq_val[i])
            ,.deq_flit  (deq_flit[i])
            ,.deq_rdy   (deq_rdy[i])
        );

        eth_rx_noc_in u_eth_rx_noc_in (
             .clk      (clk)
            ,.rst      (rst)
            ,.deq_val  (deq_val[i])
            ,.deq_flit (deq_flit[i])
            ,.deq_rdy  (deq_rdy[i])
            ,.beat_val (beat_val[i])
            ,.beat     (beat[i])
            ,.beat_rdy (beat_rdy[i])
        );
    end

    mac_frame_merge u_mac_frame_merge (
         .clk      (clk)
        ,.rst      (rst)
        ,.beat_val (beat_val)
        ,.beat     (beat)
        ,.beat_rdy (beat_rdy)
        ,.mac_val  (mac_val)
        ,.mac_beat (mac_beat)
        ,.mac_rdy  (mac_rdy)
    );

endmodule

/* hw/eth_rx_tile_cfg.svh */
`ifndef ETH_RX_TILE_CFG_SVH
`define ETH_RX_TILE_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NoC flit geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define NOC_DATA_WIDTH      64
`define NOC_DATA_BYTES      8
`define NOC_DATA_BYTES_W    3

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MAC side and header fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define MAC_INTERFACE_W     `NOC_DATA_WIDTH
`define MAC_PADBYTES_W      3
`define MTU_SIZE_W          14
`define MSG_LENGTH_WIDTH    8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lane structure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define RX_LANES            2
`define LANE_FIFO_DEPTH     8

`endif

/* hw/eth_rx_tile_pkg.sv */
`include "eth_rx_tile_cfg.svh"

package eth_rx_tile_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // NoC header flit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [`MSG_LENGTH_WIDTH-1:0] msg_len;   // data flits after the header.
        logic [7:0]                   msg_type;
    } noc_hdr_core_t;

    typedef struct packed {
        noc_hdr_core_t                                core;
        logic [`MTU_SIZE_W-1:0]                       frame_size; // frame length in bytes.
        logic [`NOC_DATA_WIDTH-16-`MTU_SIZE_W-1:0]    reserved;
    } eth_rx_hdr_flit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane FIFO entry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [`NOC_DATA_WIDTH-1:0] data;
        logic                       is_hdr;
        logic                       msg_end;  // final data flit of the message.
    } lane_flit_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // MAC beat
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [`MAC_INTERFACE_W-1:0] data;
        logic                        last;
        logic [`MAC_PADBYTES_W-1:0]  padbytes;   // only meaningful with last.
        logic [`MTU_SIZE_W-1:0]      frame_size;
    } mac_beat_t;

endpackage

/* hw/flit_fifo.sv */
`include "eth_rx_tile_cfg.svh"

module flit_fifo import eth_rx_tile_pkg::*; #(
    parameter int DEPTH = `LANE_FIFO_DEPTH
) (
     input  logic       clk
    ,input  logic       rst

    ,input  logic       push
    ,input  lane_flit_t push_flit
    ,output logic       full

    ,output logic       deq_val
    ,output lane_flit_t deq_flit
    ,input  logic       deq_rdy
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    lane_flit_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == CNT_W'(DEPTH));
    assign deq_val = (count != '0);
    assign deq_flit = mem[rd_ptr];

    assign do_push = push & ~full;
    assign do_pop  = deq_val & deq_rdy;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_flit;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers and occupancy
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither leaves the level alone.
            endcase
        end
    end

    a_push_not_full: assert property (@(posedge clk) disable iff (rst)
        push |-> !full);

endmodule

/* hw/mac_frame_merge.sv */
`include "eth_rx_tile_cfg.svh"

module mac_frame_merge import eth_rx_tile_pkg::*; (
     input  logic                 clk
    ,input  logic                 rst

    ,input  logic [`RX_LANES-1:0] beat_val
    ,input  mac_beat_t            beat [`RX_LANES]
    ,output logic [`RX_LANES-1:0] beat_rdy

    ,output logic                 mac_val
    ,output mac_beat_t            mac_beat
    ,input  logic                 mac_rdy
);

    localparam int LANE_W = (`RX_LANES > 1) ? $clog2(`RX_LANES) : 1;

    logic [LANE_W-1:0] grant;
    logic              frame_done;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output mux
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign mac_val  = beat_val[grant];
    assign mac_beat = beat[grant];

    always_comb begin
        for (int i = 0; i < `RX_LANES; i++) begin
            beat_rdy[i] = mac_rdy && (grant == LANE_W'(i));
        end
    end

    assign frame_done = mac_val & mac_rdy & mac_beat.last;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // grant rotation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= '0;
        end
        else if (frame_done) begin
            // the grant follows the steer's cyclic order so frames leave as they came.
            grant <= (grant == LANE_W'(`RX_LANES - 1))
                     ? '0
                     : grant + 1'b1;
        end
    end

    a_grant_held: assert property (@(posedge clk) disable iff (rst)
        (mac_val && !mac_rdy) |=> $stable(grant));

    // a stalled beat stays offered until the MAC takes it.
    a_val_held: assert property (@(posedge clk) disable iff (rst)
        (mac_val && !mac_rdy) |=> mac_val && $stable(mac_beat));

endmodule

/* hw/noc_msg_steer.sv */
`include "eth_rx_tile_cfg.svh"

module noc_msg_steer import eth_rx_tile_pkg::*; (
     input  logic                          clk
    ,input  logic                          rst

    ,input  logic                          noc_in_val
    ,input  logic [`NOC_DATA_WIDTH-1:0]    noc_in_data
    ,output logic                          noc_in_rdy

    ,input  logic [`RX_LANES-1:0]          lane_full
    ,output logic [`RX_LANES-1:0]          lane_push
    ,output lane_flit_t                    lane_flit
);

    localparam int LANE_W = (`RX_LANES > 1) ? $clog2(`RX_LANES) : 1;

    eth_rx_hdr_flit               hdr_cast;
    logic                         in_hdr;
    logic [`MSG_LENGTH_WIDTH-1:0] remain;
    logic [LANE_W-1:0]            lane_sel;
    logic                         accept;
    logic                         at_end;

    assign hdr_cast = noc_in_data;

    assign noc_in_rdy = ~lane_full[lane_sel];  // only the targeted lane matters.
    assign accept     = noc_in_val & noc_in_rdy;
    assign at_end     = ~in_hdr && (remain == `MSG_LENGTH_WIDTH'(1));

    assign lane_flit.data    = noc_in_data;
    assign lane_flit.is_hdr  = in_hdr;
    assign lane_flit.msg_end = at_end;

    always_comb begin
        for (int i = 0; i < `RX_LANES; i++) begin
            lane_push[i] = accept && (lane_sel == LANE_W'(i));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // message tracking and lane rotation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            in_hdr   <= 1'b1;
            remain   <= '0;
            lane_sel <= '0;
        end
        else if (accept) begin
            if (in_hdr) begin
                in_hdr <= 1'b0;
                remain <= hdr_cast.core.msg_len;  // msg_len is at least one.
            end
            else begin
                remain <= remain - 1'b1;
                if (at_end) begin
                    in_hdr   <= 1'b1;
                    lane_sel <= (lane_sel == LANE_W'(`RX_LANES - 1))
                                ? '0
                                : lane_sel + 1'b1;  // whole messages go round-robin.
                end
            end
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        (lane_push & lane_full) == '0);

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the Ethernet RX tile testbench with Verilator, run it and judge the result.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_eth_rx_tile -o tb_eth_rx_tile_sim \
    || { echo "run_sim: build failed"; exit 1; }
out=$(./obj_dir/tb_eth_rx_tile_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TESTBENCH PASSED" \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }

/* testbench/tb_eth_rx_tile.sv */
`include "eth_rx_tile_cfg.svh"

module tb_eth_rx_tile import eth_rx_tile_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_FRAMES   = 60;
    localparam int MIX_FRAMES   = 20;   // back-to-back short and long frames first.
    localparam int MAX_FLITS    = 30;
    localparam int WATCHDOG_NS  = NUM_FRAMES * MAX_FLITS * 4 * 10;
    localparam int DRAIN_CYCLES = 1000;

    logic                       clk;
    logic                       rst;
    logic                       noc_in_val;
    logic [`NOC_DATA_WIDTH-1:0] noc_in_data;
    logic                       noc_in_rdy;
    logic                       mac_val;
    mac_beat_t                  mac_beat;
    logic                       mac_rdy;

    logic [15:0] stim_lfsr;
    logic [15:0] rdy_lfsr;
    mac_beat_t   exp_q [$];
    int          value_errors;
    int          stream_errors;
    int          beats_checked;

    eth_rx_tile u_eth_rx_tile (
         .clk         (clk)
        ,.rst         (rst)
        ,.noc_in_val  (noc_in_val)
        ,.noc_in_data (noc_in_data)
        ,.noc_in_rdy  (noc_in_rdy)
        ,.mac_val     (mac_val)
        ,.mac_beat    (mac_beat)
        ,.mac_rdy     (mac_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random source and expected values
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [63:0] take_bits(inout logic [15:0] state, input int n);
        logic [63:0] r;
        logic        lsb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lsb   = state[0];
            state = state >> 1;
            if (lsb) begin
                state = state ^ 16'hB400;  // galois form of a maximal 16-bit polynomial.
            end
            r = {r[62:0], lsb};
        end
        return r;
    endfunction

    function automatic int pad_for_size(input int size);
        int rem;
        rem = size % 8;
        return (rem == 0) ? 0 : 8 - rem;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        value_errors++;
        $display("** Error: %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // NoC side driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic send_flit(input logic [63:0] data, input bit expect_beat,
                             input mac_beat_t beat_exp);
        noc_in_val  = 1'b1;
        noc_in_data = data;
        while (!noc_in_rdy) begin
            @(negedge clk);  // rdy only moves on the rising edge.
        end
        if (expect_beat) begin
            exp_q.push_back(beat_exp);
        end
        @(negedge clk);
        noc_in_val = 1'b0;
    endtask

    task automatic send_frame(input int size, input bit use_gaps);
        eth_rx_hdr_flit hdr;
        mac_beat_t      b;
        int             flits;
        int             gap;
        flits              = (size + 7) / 8;
        hdr                = '0;
        hdr.core.msg_len   = `MSG_LENGTH_WIDTH'(flits);
        hdr.core.msg_type  = 8'(take_bits(stim_lfsr, 8));
        hdr.frame_size     = `MTU_SIZE_W'(size);
        b                  = '0;
        send_flit(hdr, 1'b0, b);
        for (int k = 0; k < flits; k++) begin
            b.data       = take_bits(stim_lfsr, 64);
            b.last       = (k == flits - 1);
            b.padbytes   = `MAC_PADBYTES_W'(pad_for_size(size));
            b.frame_size = `MTU_SIZE_W'(size);
            send_flit(b.data, 1'b1, b);
            if (use_gaps) begin
                gap = int'(take_bits(stim_lfsr, 2));
                repeat (gap) @(negedge clk);
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // MAC side monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_beat();
        mac_beat_t e;
        if (exp_q.size() == 0) begin
            stream_errors++;
            $display("unexpected extra beat on the MAC output at %0t", $time);
            return;
        end
        e = exp_q.pop_front();
        beats_checked++;
        if (mac_beat.data !== e.data) begin
            report_mismatch("beat_data", e.data, mac_beat.data);
        end
        if (mac_beat.last !== e.last) begin
            report_mismatch("beat_last", 64'(e.last), 64'(mac_beat.last));
        end
        if (mac_beat.padbytes !== e.padbytes) begin
            report_mismatch("beat_padbytes", 64'(e.padbytes), 64'(mac_beat.padbytes));
        end
        if (mac_beat.frame_size !== e.frame_size) begin
            report_mismatch("beat_frame_size", 64'(e.frame_size), 64'(mac_beat.frame_size));
        end
    endtask

    initial begin
        rdy_lfsr = 16'd65;
        mac_rdy  = 1'b0;
        forever begin
            @(negedge clk);
            mac_rdy = (take_bits(rdy_lfsr, 2) != 64'd0);  // ready three cycles in four.
            #1;
            if (!rst && mac_val && mac_rdy) begin
                check_beat();
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with %0d beats still expected",
                 WATCHDOG_NS, exp_q.size());
        $display("TESTBENCH FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int size;
        int drain;
        stim_lfsr     = 16'd65;
        value_errors  = 0;
        stream_errors = 0;
        beats_checked = 0;
        rst           = 1'b1;
        noc_in_val    = 1'b0;
        noc_in_data   = '0;

        repeat (10) begin
            @(negedge clk);
            if (mac_val !== 1'b0) begin
                report_mismatch("reset_mac_val", 64'd0, 64'(mac_val));
            end
        end
        rst = 1'b0;
        #1;
        if (noc_in_rdy !== 1'b1) begin
            report_mismatch("reset_noc_in_rdy", 64'd1, 64'(noc_in_rdy));
        end
        if (mac_val !== 1'b0) begin
            report_mismatch("reset_mac_val", 64'd0, 64'(mac_val));
        end
        @(negedge clk);

        for (int f = 0; f < NUM_FRAMES; f++) begin
            if (f < MIX_FRAMES) begin
                size = (f % 2 == 0) ? 1 + int'(take_bits(stim_lfsr, 3))
                                    : 185 + int'(take_bits(stim_lfsr, 4));
            end
            else begin
                size = 1 + int'(take_bits(stim_lfsr, 8)) % 200;
            end
            send_frame(size, f >= MIX_FRAMES);
        end

        drain = 0;
        while (exp_q.size() != 0 && drain < DRAIN_CYCLES) begin
            @(negedge clk);
            drain++;
        end
        repeat (20) @(negedge clk);  // room for a stray beat to show up.
        if (exp_q.size() != 0) begin
            stream_errors++;
            $display("%0d expected beats never left the MAC output", exp_q.size());
        end

        $display("errors: %0d value, %0d stream, %0d beats checked",
                 value_errors, stream_errors, beats_checked);
        if (value_errors == 0 && stream_errors == 0) begin
            $display("TESTBENCH PASSED");
        end
        else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
